//--- hw/zcmp_seq_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types for the Zcmp sequencer. Covers push/pop and double moves
// only. Table jumps are not decoded. Emitted words are RV32 I or S format
////////////////////////////////////////////////////////////////////////////

package zcmp_seq_pkg;

  // Raw compressed word as delivered by fetch
  typedef logic [15:0] c_instr_t;

  // Decoded sequence kind
  typedef enum logic [2:0] {
    NONE,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVSA01,
    MVA01S
  } seq_kind_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_DMOVE,
    S_RA,
    S_SP,
    S_A0,
    S_RET
  } seq_state_e;

  // Number of ops already emitted, up to 15 for the longest popretz
  typedef logic [3:0] seq_cnt_t;

  // Decoder result, combinational from the compressed word
  typedef struct packed {
    seq_kind_e   kind;
    logic [3:0]  n_sregs;
    logic [11:0] total_stack_adj;
    logic [2:0]  r1s;
    logic [2:0]  r2s;
    logic        is_load;
  } seq_decode_t;

  // FSM state handed to the generator
  typedef struct packed {
    seq_state_e state;
    seq_cnt_t   cnt;
  } seq_ctrl_t;

  ////////////////////////////////////////////////////////////////////////////
  // RV32 instruction formats
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  // Same 32 bits seen as I-format, S-format or a plain word
  typedef union packed {
    i_type_t     i;
    s_type_t     s;
    logic [31:0] raw;
  } rv32_instr_u;

  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_JALR  = 7'h67;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  // s0/s1 sit at x8/x9, s2..s11 continue at x18..x27
  function automatic logic [4:0] sreg_to_regnum(input logic [3:0] sidx);
    logic [4:0] regnum;
    if (sidx < 4'd2) begin
      regnum = {4'b0100, sidx[0]};
    end else begin
      regnum = 5'd16 + {1'b0, sidx};
    end
    return regnum;
  endfunction

endpackage

//--- hw/zcmp_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Combinational Zcmp decode. Anything illegal or outside C2/101 gives NONE
// RV32E limits rlist to 6 and double move sregs to s0/s1
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zcmp_decoder import zcmp_seq_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  c_instr_t    instr_i,
  output seq_decode_t dec_o
);

  logic [3:0]  rlist;
  logic [1:0]  spimm;
  logic [2:0]  r1s;
  logic [2:0]  r2s;
  logic        rlist_legal;
  logic        dmove_legal;
  seq_kind_e   kind;
  logic [3:0]  n_sregs;
  logic [4:0]  save_words;
  logic [11:0] save_bytes;
  logic [11:0] base_adj;

  // Field extraction
  assign rlist = instr_i[7:4];
  assign spimm = instr_i[3:2];
  assign r1s   = instr_i[9:7];
  assign r2s   = instr_i[4:2];

  ////////////////////////////////////////////////////////////////////////////
  // Legality
  ////////////////////////////////////////////////////////////////////////////

  // rlist 0..3 is reserved, RV32E has no s2 and up
  assign rlist_legal = RV32E ? (rlist > 4'd3) && (rlist < 4'd7) : (rlist > 4'd3);

  // Both sregs must differ, RV32E only has s0 and s1
  assign dmove_legal = RV32E ? (r1s != r2s) && (r1s < 3'd2) && (r2s < 3'd2)
                             : (r1s != r2s);

  always_comb begin
    kind = NONE;
    // Every Zcmp op lives in quadrant C2 with funct3 101
    if ((instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101)) begin
      case (instr_i[12:10])
        3'b011: begin
          if (dmove_legal) begin
            if (instr_i[6:5] == 2'b01) begin
              kind = MVSA01;
            end else if (instr_i[6:5] == 2'b11) begin
              kind = MVA01S;
            end
          end
        end
        3'b110: begin
          if (rlist_legal) begin
            if (instr_i[9:8] == 2'b00) begin
              kind = PUSH;
            end else if (instr_i[9:8] == 2'b10) begin
              kind = POP;
            end
          end
        end
        3'b111: begin
          if (rlist_legal) begin
            if (instr_i[9:8] == 2'b00) begin
              kind = POPRETZ;
            end else if (instr_i[9:8] == 2'b10) begin
              kind = POPRET;
            end
          end
        end
        default: kind = NONE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register count and stack frame
  ////////////////////////////////////////////////////////////////////////////

  // rlist 15 saves s0..s11, the encoding skips a 11-register case
  assign n_sregs = (rlist == 4'd15) ? 4'd12 : rlist - 4'd4;

  // Saved sregs plus ra, rounded up to 16 bytes
  assign save_words = {1'b0, n_sregs} + 5'd1;
  assign save_bytes = {5'b0, save_words, 2'b00};
  assign base_adj   = (save_bytes + 12'd15) & 12'hff0;

  assign dec_o.kind            = kind;
  assign dec_o.n_sregs         = n_sregs;
  // spimm adds extra 16-byte blocks on top of the frame
  assign dec_o.total_stack_adj = base_adj + {6'b0, spimm, 4'b0000};
  assign dec_o.r1s             = r1s;
  assign dec_o.r2s             = r2s;
  assign dec_o.is_load         = (kind == POP) || (kind == POPRET) || (kind == POPRETZ);

  // Nothing outside C2 may ever start a sequence
  a_quadrant_none: assert final ((instr_i[1:0] == 2'b10) || (dec_o.kind == NONE));

endmodule

//--- hw/zcmp_seq_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Sequence FSM and op counter. Advances one op per valid/ready transfer
// Input word must stay stable until the last op is accepted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zcmp_seq_fsm import zcmp_seq_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  seq_decode_t dec_i,
  input  logic        valid_i,
  input  logic        ready_i,
  input  logic        halt_i,
  input  logic        kill_i,
  output seq_ctrl_t   ctrl_o,
  output logic        valid_o,
  output logic        ready_o,
  output logic        first_o,
  output logic        last_o,
  output logic        pushpop_o
);

  seq_state_e state_q;
  seq_state_e state_n;
  seq_cnt_t   cnt_q;
  logic       is_dmove;

  assign is_dmove  = (dec_i.kind == MVSA01) || (dec_i.kind == MVA01S);
  assign pushpop_o = (dec_i.kind == PUSH) || dec_i.is_load;

  // Halt and kill both mask the output
  assign valid_o = (dec_i.kind != NONE) && valid_i && !halt_i && !kill_i;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    last_o  = 1'b0;
    case (state_q)
      S_IDLE: begin
        // First op goes out from idle, pick where the rest continues
        if (is_dmove) begin
          state_n = S_DMOVE;
        end else if (pushpop_o) begin
          if (dec_i.n_sregs > 4'd1) begin
            state_n = dec_i.is_load ? S_POP : S_PUSH;
          end else if (dec_i.n_sregs == 4'd1) begin
            state_n = S_RA;
          end else begin
            state_n = S_SP;
          end
        end
      end
      S_PUSH, S_POP: begin
        // Last sreg done, ra follows
        if (cnt_q == dec_i.n_sregs - 4'd1) begin
          state_n = S_RA;
        end
      end
      S_RA: state_n = S_SP;
      S_SP: begin
        if (dec_i.kind == POPRETZ) begin
          state_n = S_A0;
        end else if (dec_i.kind == POPRET) begin
          state_n = S_RET;
        end else begin
          state_n = S_IDLE;
          last_o  = 1'b1;
        end
      end
      S_A0: state_n = S_RET;
      S_DMOVE, S_RET: begin
        state_n = S_IDLE;
        last_o  = 1'b1;
      end
      default: state_n = S_IDLE;
    endcase
  end

  // Take the next word after the last op, or whenever nothing is emitted
  assign ready_o = (last_o && ready_i && !halt_i) || (!valid_o && !halt_i) || kill_i;
  assign first_o = (state_q == S_IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // State and counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (valid_o && ready_i) begin
      state_q <= state_n;
      cnt_q   <= last_o ? '0 : cnt_q + 4'd1;
    end else if (kill_i) begin
      // Abandon the sequence
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end
  end

  assign ctrl_o.state = state_q;
  assign ctrl_o.cnt   = cnt_q;

  // Halt freezes everything unless a kill overrides it
  a_halt_stable: assert property (@(posedge clk) disable iff (!rst_n)
    halt_i && !kill_i |=> $stable(state_q) && $stable(cnt_q));

  // Every finished or killed sequence leaves a clean counter
  a_idle_cnt_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == S_IDLE) |-> (cnt_q == '0));

endmodule

//--- hw/zcmp_instr_gen.sv
////////////////////////////////////////////////////////////////////////////
// Builds the emitted RV32 word from state, counter and decode
// Output is don't-care-zero when no sequence is active
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zcmp_instr_gen import zcmp_seq_pkg::*; (
  input  seq_decode_t dec_i,
  input  seq_ctrl_t   ctrl_i,
  output rv32_instr_u instr_o
);

  // funct3 for lw/sw and for addi/jalr
  localparam logic [2:0] F3_WORD = 3'b010;
  localparam logic [2:0] F3_ZERO = 3'b000;

  logic [3:0]  sidx;
  logic [4:0]  s_reg;
  logic [4:0]  dm_r1;
  logic [4:0]  dm_r2;
  logic [4:0]  cnt_inc;
  logic [11:0] step;
  logic [11:0] offset;

  function automatic rv32_instr_u itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opcode);
    rv32_instr_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = opcode;
    return w;
  endfunction

  function automatic rv32_instr_u stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [6:0] opcode);
    rv32_instr_u w;
    w.s.imm_hi = imm[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = f3;
    w.s.imm_lo = imm[4:0];
    w.s.opcode = opcode;
    return w;
  endfunction

  // lw r, off(sp) or sw r, off(sp)
  function automatic rv32_instr_u mem_word(input logic ld, input logic [11:0] off,
                                           input logic [4:0] r);
    rv32_instr_u w;
    if (ld) begin
      w = itype(off, REG_SP, F3_WORD, r, OPCODE_LOAD);
    end else begin
      w = stype(off, r, REG_SP, F3_WORD, OPCODE_STORE);
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register and offset for the current op
  ////////////////////////////////////////////////////////////////////////////

  // Highest sreg goes first
  assign sidx  = dec_i.n_sregs - ctrl_i.cnt - 4'd1;
  assign s_reg = sreg_to_regnum(sidx);
  assign dm_r1 = sreg_to_regnum({1'b0, dec_i.r1s});
  assign dm_r2 = sreg_to_regnum({1'b0, dec_i.r2s});

  // Push stores downward from -4, pop rewinds from the frame top
  assign cnt_inc = {1'b0, ctrl_i.cnt} + 5'd1;
  assign step    = {5'b0, cnt_inc, 2'b00};
  assign offset  = dec_i.is_load ? dec_i.total_stack_adj - step : 12'd0 - step;

  always_comb begin
    instr_o.raw = '0;
    case (ctrl_i.state)
      S_IDLE: begin
        if (dec_i.kind == MVSA01) begin
          // addi s(r1s), a0, 0
          instr_o = itype(12'h000, REG_A0, F3_ZERO, dm_r1, OPCODE_OPIMM);
        end else if (dec_i.kind == MVA01S) begin
          // addi a0, s(r1s), 0
          instr_o = itype(12'h000, dm_r1, F3_ZERO, REG_A0, OPCODE_OPIMM);
        end else if (dec_i.kind != NONE) begin
          // No sregs means ra is the first transfer
          instr_o = mem_word(dec_i.is_load, offset,
                             (dec_i.n_sregs != 4'd0) ? s_reg : REG_RA);
        end
      end
      S_PUSH, S_POP: instr_o = mem_word(dec_i.is_load, offset, s_reg);
      S_RA:          instr_o = mem_word(dec_i.is_load, offset, REG_RA);
      S_SP: begin
        // Pops release the frame, push allocates it
        instr_o = itype(dec_i.is_load ? dec_i.total_stack_adj : 12'd0 - dec_i.total_stack_adj,
                        REG_SP, F3_ZERO, REG_SP, OPCODE_OPIMM);
      end
      S_A0:  instr_o = itype(12'h000, REG_ZERO, F3_ZERO, REG_A0, OPCODE_OPIMM);
      S_RET: instr_o = itype(12'h000, REG_RA, F3_ZERO, REG_ZERO, OPCODE_JALR);
      S_DMOVE: begin
        if (dec_i.kind == MVSA01) begin
          instr_o = itype(12'h000, REG_A1, F3_ZERO, dm_r2, OPCODE_OPIMM);
        end else begin
          instr_o = itype(12'h000, dm_r2, F3_ZERO, REG_A1, OPCODE_OPIMM);
        end
      end
      default: instr_o.raw = '0;
    endcase
  end

  // Stack accesses stay word aligned, relies on the decoder frame rounding
  a_mem_aligned: assert final (
    ((instr_o.i.opcode != OPCODE_LOAD) || (instr_o.i.imm[1:0] == 2'b00)) &&
    ((instr_o.s.opcode != OPCODE_STORE) || (instr_o.s.imm_lo[1:0] == 2'b00)));

endmodule

//--- hw/zcmp_seq.sv
////////////////////////////////////////////////////////////////////////////
// Zcmp sequencer top. Outputs are combinational from inputs and state
// Fetch must hold instr_i stable until ready_o while a sequence runs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zcmp_seq import zcmp_seq_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  c_instr_t    instr_i,
  input  logic        valid_i,
  input  logic        ready_i,
  input  logic        halt_i,
  input  logic        kill_i,
  output rv32_instr_u instr_o,
  output logic        valid_o,
  output logic        ready_o,
  output logic        first_o,
  output logic        last_o,
  output logic        pushpop_o
);

  seq_decode_t dec;
  seq_ctrl_t   ctrl;

  // Decode of the held compressed word
  zcmp_decoder #(
    .RV32E (RV32E)
  ) u_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  // Sequencing and handshake
  zcmp_seq_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_i     (dec),
    .valid_i   (valid_i),
    .ready_i   (ready_i),
    .halt_i    (halt_i),
    .kill_i    (kill_i),
    .ctrl_o    (ctrl),
    .valid_o   (valid_o),
    .ready_o   (ready_o),
    .first_o   (first_o),
    .last_o    (last_o),
    .pushpop_o (pushpop_o)
  );

  // Word builder for the current op
  zcmp_instr_gen u_instr_gen (
    .dec_i   (dec),
    .ctrl_i  (ctrl),
    .instr_o (instr_o)
  );

endmodule

//--- include/zcmp_seq_vectors.svh
////////////////////////////////////////////////////////////////////////////
// Zcmp test table, included inside the testbench module after the import
// Expected words assume RV32E cleared and highest s register stored first
////////////////////////////////////////////////////////////////////////////

`ifndef ZCMP_SEQ_VECTORS_SVH
`define ZCMP_SEQ_VECTORS_SVH

localparam int NUM_ROWS = 16;
localparam int NUM_OPS  = 42;

// Compressed word, legal, pushpop marker, number of emitted ops
typedef struct packed {
  c_instr_t   word;
  logic       legal;
  logic       pushpop;
  logic [4:0] n_ops;
} vec_row_t;

localparam vec_row_t ROWS [0:NUM_ROWS-1] = '{
  {16'hB842, 1'b1, 1'b1, 5'd2},   // cm.push {ra}, -16
  {16'hB856, 1'b1, 1'b1, 5'd3},   // cm.push {ra,s0}, -32
  {16'hB87A, 1'b1, 1'b1, 5'd5},   // cm.push {ra,s0-s2}, -48
  {16'hB8FE, 1'b1, 1'b1, 5'd14},  // cm.push {ra,s0-s11}, -112
  {16'hBA52, 1'b1, 1'b1, 5'd3},   // cm.pop {ra,s0}, 16
  {16'hBE66, 1'b1, 1'b1, 5'd5},   // cm.popret {ra,s0-s1}, 32
  {16'hBC4A, 1'b1, 1'b1, 5'd4},   // cm.popretz {ra}, 48
  {16'hAC26, 1'b1, 1'b0, 5'd2},   // cm.mvsa01 s0, s1
  {16'hAFEA, 1'b1, 1'b0, 5'd2},   // cm.mva01s s7, s2
  {16'hADB6, 1'b1, 1'b0, 5'd2},   // cm.mvsa01 s3, s5
  {16'hB802, 1'b0, 1'b0, 5'd0},   // Push with rlist 0
  {16'hBA32, 1'b0, 1'b0, 5'd0},   // Pop with rlist 3
  {16'hBC22, 1'b0, 1'b0, 5'd0},   // Popretz with rlist 2
  {16'hBE16, 1'b0, 1'b0, 5'd0},   // Popret with rlist 1
  {16'hAD2A, 1'b0, 1'b0, 5'd0},   // Double move with r1s equal r2s
  {16'hB841, 1'b0, 1'b0, 5'd0}    // Quadrant 01, not Zcmp
};

// Emitted words of all legal rows back to back, in row order
localparam logic [31:0] OPS [0:NUM_OPS-1] = '{
  32'hFE112E23, 32'hFF010113,
  32'hFE812E23, 32'hFE112C23, 32'hFE010113,
  32'hFF212E23, 32'hFE912C23, 32'hFE812A23, 32'hFE112823, 32'hFD010113,
  // Twelve s registers from s11 down, then ra and the adjust
  32'hFFB12E23, 32'hFFA12C23, 32'hFF912A23, 32'hFF812823,
  32'hFF712623, 32'hFF612423, 32'hFF512223, 32'hFF412023,
  32'hFD312E23, 32'hFD212C23, 32'hFC912A23, 32'hFC812823,
  32'hFC112623, 32'hF9010113,
  32'h00C12403, 32'h00812083, 32'h01010113,
  32'h01C12483, 32'h01812403, 32'h01412083, 32'h02010113, 32'h00008067,
  32'h02C12083, 32'h03010113, 32'h00000513, 32'h00008067,
  32'h00050413, 32'h00058493,
  32'h000B8513, 32'h00090593,
  32'h00050993, 32'h00058A93
};

`endif

//--- tb/zcmp_seq_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the Zcmp sequencer with RV32E cleared
// Stops at the first mismatch, ready_i stalls come from a seeded $urandom
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module zcmp_seq_tb import zcmp_seq_pkg::*;;

  `include "zcmp_seq_vectors.svh"

  // Push row cut short by halt and kill, then replayed
  localparam int KILL_ROW   = 2;
  localparam int KILL_AFTER = 2;

  logic        clk;
  logic        rst_n;
  c_instr_t    instr_i;
  logic        valid_i;
  logic        ready_i;
  logic        halt_i;
  logic        kill_i;
  rv32_instr_u instr_o;
  logic        valid_o;
  logic        ready_o;
  logic        first_o;
  logic        last_o;
  logic        pushpop_o;

  int          op_base [0:NUM_ROWS-1];
  int          cycle_cnt   = 0;
  int          cycle_limit = 1000;

  zcmp_seq #(
    .RV32E (1'b0)
  ) zcmp_seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_i   (instr_i),
    .valid_i   (valid_i),
    .ready_i   (ready_i),
    .halt_i    (halt_i),
    .kill_i    (kill_i),
    .instr_o   (instr_o),
    .valid_o   (valid_o),
    .ready_o   (ready_o),
    .first_o   (first_o),
    .last_o    (last_o),
    .pushpop_o (pushpop_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: sequence never ended");
      $display("RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_instr(input string name, input rv32_instr_u got,
                               input rv32_instr_u exp);
    if (got.raw !== exp.raw) begin
      $display("FAILED at %0t: %s = %08h, expected %08h", $time, name, got.raw, exp.raw);
      $display("RESULT: FAIL");
      $fatal(1, "instruction word mismatch");
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "control flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Present one row and follow it for stop_after accepted ops
  task automatic run_sequence(input int r, input int stop_after);
    vec_row_t    row;
    rv32_instr_u exp_w;
    int          k;
    row = ROWS[r];
    k   = 0;
    @(posedge clk);
    instr_i <= row.word;
    valid_i <= 1'b1;
    ready_i <= ($urandom % 4) != 0;
    while (k < stop_after) begin
      @(negedge clk);
      // Word must hold through stalls, so expect op k every cycle
      exp_w.raw = OPS[op_base[r] + k];
      compare_bit("valid_o", valid_o, 1'b1);
      compare_instr("instr_o", instr_o, exp_w);
      compare_bit("first_o", first_o, k == 0);
      compare_bit("last_o", last_o, k == int'(row.n_ops) - 1);
      compare_bit("pushpop_o", pushpop_o, row.pushpop);
      compare_bit("ready_o", ready_o, (k == int'(row.n_ops) - 1) && ready_i);
      if (ready_i) begin
        k++;
      end
      if (k < stop_after) begin
        @(posedge clk);
        ready_i <= ($urandom % 4) != 0;
      end
    end
  endtask

  // Illegal word is dropped at once
  task automatic apply_illegal(input int r);
    @(posedge clk);
    instr_i <= ROWS[r].word;
    valid_i <= 1'b1;
    ready_i <= ($urandom % 4) != 0;
    @(negedge clk);
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b1);
    compare_bit("pushpop_o", pushpop_o, ROWS[r].pushpop);
  endtask

  // Halt then kill mid push, the same word must restart from op 1
  task automatic kill_and_restart();
    rv32_instr_u exp_w;
    run_sequence(KILL_ROW, KILL_AFTER);
    @(posedge clk);
    // Downstream stays ready, so only halt can keep op 2 in place
    halt_i  <= 1'b1;
    ready_i <= 1'b1;
    @(negedge clk);
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b0);
    @(posedge clk);
    halt_i  <= 1'b0;
    ready_i <= 1'b0;
    @(negedge clk);
    exp_w.raw = OPS[op_base[KILL_ROW] + KILL_AFTER];
    compare_instr("instr_o", instr_o, exp_w);
    compare_bit("first_o", first_o, 1'b0);
    @(posedge clk);
    kill_i <= 1'b1;
    @(negedge clk);
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b1);
    @(posedge clk);
    kill_i <= 1'b0;
    run_sequence(KILL_ROW, ROWS[KILL_ROW].n_ops);
  endtask

  initial begin
    int base;
    int total;
    rst_n   = 1'b0;
    instr_i = '0;
    valid_i = 1'b0;
    ready_i = 1'b0;
    halt_i  = 1'b0;
    kill_i  = 1'b0;
    void'($urandom(32'hfbe6_6023));

    // Op offsets per row and the cycle budget
    base  = 0;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      op_base[r] = base;
      base  += ROWS[r].n_ops;
      total += (ROWS[r].n_ops > 0) ? ROWS[r].n_ops : 1;
    end
    total += KILL_AFTER + 3 + ROWS[KILL_ROW].n_ops;
    cycle_limit = total * 4 + 200;
    if (base != NUM_OPS) begin
      $display("test table row counts do not add up to the op list length");
      $display("RESULT: FAIL");
      $fatal(1, "bad test table");
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // Idle after reset accepts fetch
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b1);
    compare_bit("first_o", first_o, 1'b1);

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (ROWS[r].legal) begin
        run_sequence(r, ROWS[r].n_ops);
      end else begin
        apply_illegal(r);
      end
    end

    kill_and_restart();

    @(posedge clk);
    valid_i <= 1'b0;
    @(negedge clk);
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b1);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- zcmp_seq.f
+incdir+include
hw/zcmp_seq_pkg.sv
hw/zcmp_decoder.sv
hw/zcmp_seq_fsm.sv
hw/zcmp_instr_gen.sv
hw/zcmp_seq.sv
tb/zcmp_seq_tb.sv

//--- Bender.yml
package:
  name: zcmp_seq

sources:
  - hw/zcmp_seq_pkg.sv
  - hw/zcmp_decoder.sv
  - hw/zcmp_seq_fsm.sv
  - hw/zcmp_instr_gen.sv
  - hw/zcmp_seq.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/zcmp_seq_tb.sv
